// File: hw/icache_pkg.sv
// Instruction cache shared definitions.
// Bus widths, refill controller states and AXI response codes.
`default_nettype none

package icache_pkg;

	// Byte address and instruction word widths.
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// Controller states for the clear sweep and the refill sequence.
	typedef enum logic [2:0] {
		CLEARING   = 3'd0,
		LOOKUP     = 3'd1,
		FILL_ISSUE = 3'd2,
		FILL_WAIT  = 3'd3,
		FILL_WRITE = 3'd4
	} fill_state_t;

	// AXI RRESP / BRESP encodings.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

endpackage

`default_nettype wire

// File: hw/icache_bram_1r1w.sv
// Instruction cache line storage.
// Simple dual-port RAM holding valid, tag and data per set, with one
// registered read port and one write port on the same clock.
`timescale 1ns/1ps
`default_nettype none

module icache_bram_1r1w
	import icache_pkg::*;
#(
	parameter int set_bits = 8
) (
	input wire i_clock,

	input wire [set_bits-1:0] i_rd_set,
	output logic [addr_w-set_bits-2+data_w:0] o_rd_entry,

	input wire i_wr_en,
	input wire [set_bits-1:0] i_wr_set,
	input wire [addr_w-set_bits-2+data_w:0] i_wr_entry
);
	localparam int tag_w = addr_w - 2 - set_bits;
	localparam int entry_w = 1 + tag_w + data_w;
	localparam int depth = 1 << set_bits;

	logic [entry_w-1:0] mem [0:depth-1];

	// Read returns the old entry when the same set is written.
	always_ff @(posedge i_clock) begin
		if (i_wr_en) begin
			mem[i_wr_set] <= i_wr_entry;
		end
		o_rd_entry <= mem[i_rd_set];
	end

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
// Instruction cache controller.
// Looks up the held fetch PC, steers the read port to the next set on a hit,
// sweeps all sets invalid after reset or invalidate, runs refills through
// the AXI reader and keeps the hit and miss counters.
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
	import icache_pkg::*;
#(
	parameter int set_bits = 8
) (
	input wire i_clock,
	input wire i_reset,

	input wire i_fetch_valid,
	input wire [addr_w-1:0] i_fetch_pc,
	input wire i_invalidate,
	output logic o_fetch_ready,
	output logic [data_w-1:0] o_fetch_data,

	output logic [set_bits-1:0] o_rd_set,
	input wire i_rd_valid,
	input wire [addr_w-set_bits-3:0] i_rd_tag,
	input wire [data_w-1:0] i_rd_data,

	output logic o_wr_en,
	output logic [set_bits-1:0] o_wr_set,
	output logic o_wr_valid,
	output logic [addr_w-set_bits-3:0] o_wr_tag,
	output logic [data_w-1:0] o_wr_data,

	output logic o_fill_req,
	output logic [addr_w-1:0] o_fill_addr,
	input wire i_fill_done,
	input wire [data_w-1:0] i_fill_data,

	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);
	localparam int tag_w = addr_w - 2 - set_bits;

	fill_state_t state;

	logic [set_bits-1:0] set_r;
	logic [set_bits-1:0] clear_set;
	logic [set_bits-1:0] pc_set;
	logic [set_bits-1:0] fill_set;
	logic [tag_w-1:0] pc_tag;
	logic [tag_w-1:0] fill_tag;
	logic inv_pending;
	logic refilled;
	logic lookup;
	logic match;
	logic hit;
	logic miss;
	logic inv_req;

	assign pc_set = i_fetch_pc[set_bits+1:2];
	assign pc_tag = i_fetch_pc[addr_w-1:set_bits+2];
	assign fill_set = o_fill_addr[set_bits+1:2];
	assign fill_tag = o_fill_addr[addr_w-1:set_bits+2];

	// The RAM output is only meaningful when it belongs to the PC's set.
	assign lookup = (state == LOOKUP) && i_fetch_valid && (set_r == pc_set);
	assign match = i_rd_valid && (i_rd_tag == pc_tag);
	assign hit = lookup && match;
	assign inv_req = i_invalidate || inv_pending;
	assign miss = lookup && !match && !inv_req;

	assign o_fetch_ready = hit;
	assign o_fetch_data = i_rd_data;

	// On a hit, prefetch the next set so a sequential PC hits at once.
	// Outside lookup the read is kept off the PC's set, so a stale line
	// never looks current when lookup resumes.
	assign o_rd_set = (state == LOOKUP && !hit) ? pc_set : pc_set + 1'b1;

	always_ff @(posedge i_clock) begin
		set_r <= o_rd_set;
	end

	// Write port serves both the sweep and the refill.
	assign o_wr_en = (state == CLEARING) || (state == FILL_WRITE);
	assign o_wr_set = (state == FILL_WRITE) ? fill_set : clear_set;
	assign o_wr_valid = (state == FILL_WRITE);
	assign o_wr_tag = (state == FILL_WRITE) ? fill_tag : '0;
	assign o_wr_data = (state == FILL_WRITE) ? i_fill_data : '0;

	assign o_fill_req = (state == FILL_ISSUE);

	// Line address of the missing fetch.
	always_ff @(posedge i_clock) begin
		if (miss) begin
			o_fill_addr <= {i_fetch_pc[addr_w-1:2], 2'b00};
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CLEARING;
			clear_set <= '0;
			inv_pending <= 1'b0;
			refilled <= 1'b0;
			o_hit <= '0;
			o_miss <= '0;
		end else begin
			// The ready that ends a refill is not a hit.
			if (hit) begin
				refilled <= 1'b0;
				if (!refilled) begin
					o_hit <= o_hit + 1'b1;
				end
			end
			if (miss) begin
				o_miss <= o_miss + 1'b1;
			end

			// Held until the refill in flight has written its line.
			if (i_invalidate) begin
				inv_pending <= 1'b1;
			end

			case (state)
				CLEARING: begin
					inv_pending <= 1'b0;
					refilled <= 1'b0;
					if (i_invalidate) begin
						clear_set <= '0;
					end else begin
						clear_set <= clear_set + 1'b1;
						if (clear_set == '1) begin
							state <= LOOKUP;
						end
					end
				end
				LOOKUP: begin
					if (inv_req) begin
						state <= CLEARING;
						clear_set <= '0;
						inv_pending <= 1'b0;
					end else if (miss) begin
						state <= FILL_ISSUE;
					end
				end
				FILL_ISSUE: begin
					state <= FILL_WAIT;
				end
				FILL_WAIT: begin
					if (i_fill_done) begin
						state <= FILL_WRITE;
					end
				end
				FILL_WRITE: begin
					state <= LOOKUP;
					refilled <= 1'b1;
				end
				default: begin
					state <= CLEARING;
					clear_set <= '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_axil_reader.sv
// AXI4-Lite read master for cache refills.
// Turns one fill request into one AR/R transaction and returns the word.
`timescale 1ns/1ps
`default_nettype none

module icache_axil_reader
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	input wire i_fill_req,
	input wire [addr_w-1:0] i_fill_addr,
	output logic o_fill_done,
	output logic [data_w-1:0] o_fill_data,

	output logic [addr_w-1:0] o_araddr,
	output logic [2:0] o_arprot,
	output logic o_arvalid,
	input wire i_arready,

	input wire i_rvalid,
	input wire [data_w-1:0] i_rdata,
	input wire axi_resp_t i_rresp,
	output logic o_rready
);
	// Unprivileged, secure, instruction access.
	assign o_arprot = 3'b100;

	// Address phase, then data phase; idle when neither is active.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_arvalid <= 1'b0;
			o_rready <= 1'b0;
			o_fill_done <= 1'b0;
		end else begin
			o_fill_done <= 1'b0;
			if (i_fill_req && !o_arvalid && !o_rready) begin
				o_arvalid <= 1'b1;
			end
			if (o_arvalid && i_arready) begin
				o_arvalid <= 1'b0;
				o_rready <= 1'b1;
			end
			if (o_rready && i_rvalid) begin
				o_rready <= 1'b0;
				o_fill_done <= 1'b1;
			end
		end
	end

	// Address is held stable until AR is accepted; data stays until the next fill.
	// The response code is not acted on, the word is passed on as returned.
	always_ff @(posedge i_clock) begin
		if (i_fill_req && !o_arvalid && !o_rready) begin
			o_araddr <= i_fill_addr;
		end
		if (o_rready && i_rvalid) begin
			o_fill_data <= i_rdata;
		end
	end

endmodule

`default_nettype wire

// File: hw/icache_top.sv
// Direct-mapped instruction cache top level.
// Joins the controller, the line RAM and the AXI4-Lite refill reader.
`timescale 1ns/1ps
`default_nettype none

module icache_top
	import icache_pkg::*;
#(
	parameter int set_bits = 8
) (
	input wire i_clock,
	input wire i_reset,

	input wire i_fetch_valid,
	input wire [addr_w-1:0] i_fetch_pc,
	input wire i_invalidate,
	output logic o_fetch_ready,
	output logic [data_w-1:0] o_fetch_data,

	output logic [addr_w-1:0] o_araddr,
	output logic [2:0] o_arprot,
	output logic o_arvalid,
	input wire i_arready,

	input wire i_rvalid,
	input wire [data_w-1:0] i_rdata,
	input wire axi_resp_t i_rresp,
	output logic o_rready,

	output logic [31:0] o_hit,
	output logic [31:0] o_miss
);
	localparam int tag_w = addr_w - 2 - set_bits;
	localparam int entry_w = 1 + tag_w + data_w;

	logic [set_bits-1:0] rd_set;
	logic [entry_w-1:0] rd_entry;
	logic wr_en;
	logic [set_bits-1:0] wr_set;
	logic wr_valid;
	logic [tag_w-1:0] wr_tag;
	logic [data_w-1:0] wr_data;
	logic [entry_w-1:0] wr_entry;
	logic fill_req;
	logic [addr_w-1:0] fill_addr;
	logic fill_done;
	logic [data_w-1:0] fill_data;

	// Entry layout is {valid, tag, data}.
	assign wr_entry = {wr_valid, wr_tag, wr_data};

	icache_ctrl #(
		.set_bits(set_bits)
	) u_ctrl (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fetch_valid(i_fetch_valid),
		.i_fetch_pc(i_fetch_pc),
		.i_invalidate(i_invalidate),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_data(o_fetch_data),
		.o_rd_set(rd_set),
		.i_rd_valid(rd_entry[entry_w-1]),
		.i_rd_tag(rd_entry[entry_w-2:data_w]),
		.i_rd_data(rd_entry[data_w-1:0]),
		.o_wr_en(wr_en),
		.o_wr_set(wr_set),
		.o_wr_valid(wr_valid),
		.o_wr_tag(wr_tag),
		.o_wr_data(wr_data),
		.o_fill_req(fill_req),
		.o_fill_addr(fill_addr),
		.i_fill_done(fill_done),
		.i_fill_data(fill_data),
		.o_hit(o_hit),
		.o_miss(o_miss)
	);

	icache_bram_1r1w #(
		.set_bits(set_bits)
	) u_bram (
		.i_clock(i_clock),
		.i_rd_set(rd_set),
		.o_rd_entry(rd_entry),
		.i_wr_en(wr_en),
		.i_wr_set(wr_set),
		.i_wr_entry(wr_entry)
	);

	icache_axil_reader u_reader (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_fill_req(fill_req),
		.i_fill_addr(fill_addr),
		.o_fill_done(fill_done),
		.o_fill_data(fill_data),
		.o_araddr(o_araddr),
		.o_arprot(o_arprot),
		.o_arvalid(o_arvalid),
		.i_arready(i_arready),
		.i_rvalid(i_rvalid),
		.i_rdata(i_rdata),
		.i_rresp(i_rresp),
		.o_rready(o_rready)
	);

endmodule

`default_nettype wire

// File: sim/icache_checker.sv
// Instruction cache protocol checker.
// Concurrent assertions on the AXI read handshakes and on the clear sweep,
// bound into every icache_top instance.
`timescale 1ns/1ps
`default_nettype none

module icache_checker
	import icache_pkg::*;
(
	input wire i_clock,
	input wire i_reset,
	input wire fill_state_t i_state,
	input wire i_fetch_ready,
	input wire [addr_w-1:0] i_araddr,
	input wire i_arvalid,
	input wire i_arready,
	input wire i_rvalid,
	input wire i_rready
);
	int fail_count = 0;
	logic ar_open;

	// Set between the AR handshake and the matching R handshake.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			ar_open <= 1'b0;
		end else if (i_arvalid && i_arready) begin
			ar_open <= 1'b1;
		end else if (i_rvalid && i_rready) begin
			ar_open <= 1'b0;
		end
	end

	ar_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr)))
	else begin
		$error("AR valid dropped or address changed before acceptance");
		fail_count++;
	end

	quiet_clear: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_state == CLEARING) |-> (!i_fetch_ready && !i_arvalid))
	else begin
		$error("Fetch ready or AR valid high during the clear sweep");
		fail_count++;
	end

	single_ar: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_arvalid && i_arready) |-> !ar_open)
	else begin
		$error("Second AR accepted before the first R beat");
		fail_count++;
	end

	r_after_ar: assert property (@(posedge i_clock) disable iff (i_reset)
		i_rready |-> ar_open)
	else begin
		$error("R ready high with no AR outstanding");
		fail_count++;
	end

endmodule

bind icache_top icache_checker u_checker (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_state(u_ctrl.state),
	.i_fetch_ready(o_fetch_ready),
	.i_araddr(o_araddr),
	.i_arvalid(o_arvalid),
	.i_arready(i_arready),
	.i_rvalid(i_rvalid),
	.i_rready(o_rready)
);

`default_nettype wire

// File: sim/icache_tb.sv
// Instruction cache testbench.
// Random fetches against an AXI4-Lite memory model with random delays,
// a tag model for hit and miss counts, and invalidate sweeps.
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
	import icache_pkg::*;

	localparam int set_bits = 4;
	localparam int tag_w = addr_w - 2 - set_bits;
	localparam int num_sets = 1 << set_bits;
	localparam int clock_period = 20;
	localparam int num_fetches = 400;
	localparam logic [addr_w-1:0] window_base = 32'h0000_1000;
	localparam int window_words = 96;
	localparam int max_delay = 5;
	localparam int max_fetches = 2 * num_fetches + num_sets;
	localparam int miss_cycles = 30;
	localparam int limit_cycles = max_fetches * miss_cycles + 3 * num_sets + 10 + 500;
	// AXI ARPROT for an unprivileged, secure instruction access.
	localparam logic [2:0] instr_prot = 3'b100;

	logic clock = 1'b0;
	logic reset;
	logic fetch_valid;
	logic [addr_w-1:0] fetch_pc;
	logic invalidate;
	logic fetch_ready;
	logic [data_w-1:0] fetch_data;
	logic [addr_w-1:0] araddr;
	logic [2:0] arprot;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic [data_w-1:0] rdata;
	axi_resp_t rresp;
	logic rready;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	// Tag model and expected counters.
	logic model_valid [num_sets];
	logic [tag_w-1:0] model_tag [num_sets];
	logic [31:0] model_hits;
	logic [31:0] model_misses;
	logic ar_expected;
	logic [addr_w-1:0] ar_expected_pc;

	icache_top #(
		.set_bits(set_bits)
	) uut (
		.i_clock(clock),
		.i_reset(reset),
		.i_fetch_valid(fetch_valid),
		.i_fetch_pc(fetch_pc),
		.i_invalidate(invalidate),
		.o_fetch_ready(fetch_ready),
		.o_fetch_data(fetch_data),
		.o_araddr(araddr),
		.o_arprot(arprot),
		.o_arvalid(arvalid),
		.i_arready(arready),
		.i_rvalid(rvalid),
		.i_rdata(rdata),
		.i_rresp(rresp),
		.o_rready(rready),
		.o_hit(hit_count),
		.o_miss(miss_count)
	);

	always #(clock_period / 2) clock = ~clock;

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [data_w-1:0] expected,
			input logic [data_w-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_resp(input string name, input axi_resp_t expected,
			input axi_resp_t actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %s actual %s", name, expected.name(), actual.name());
			abort_run();
		end
	endtask

	task automatic check_prot(input string name, input logic [2:0] expected,
			input logic [2:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %b actual %b", name, expected, actual);
			abort_run();
		end
	endtask

	// Memory contents: a fixed mix of the word address.
	function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] addr);
		logic [data_w-1:0] mixed;
		mixed = addr * 32'h9e37_79b1;
		return mixed ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1_e995;
	endfunction

	// Slave decode: OKAY inside the memory window, DECERR elsewhere.
	function automatic axi_resp_t decode_resp(input logic [addr_w-1:0] addr);
		if (addr >= window_base && addr < window_base + window_words * 4) begin
			return OKAY;
		end
		return DECERR;
	endfunction

	function automatic logic [addr_w-1:0] random_pc();
		return window_base + ($urandom_range(0, window_words - 1) << 2);
	endfunction

	function automatic logic [addr_w-1:0] next_pc(input logic [addr_w-1:0] pc);
		if (pc + 4 >= window_base + window_words * 4) begin
			return window_base;
		end
		return pc + 4;
	endfunction

	// One fetch, held until ready. Called and returns at 1 ns after a rising edge.
	task automatic fetch_word(input logic [addr_w-1:0] pc);
		logic [set_bits-1:0] set;
		logic [tag_w-1:0] tag;
		set = pc[set_bits+1:2];
		tag = pc[addr_w-1:set_bits+2];
		if (!model_valid[set] || model_tag[set] != tag) begin
			model_misses = model_misses + 1;
			model_valid[set] = 1'b1;
			model_tag[set] = tag;
			ar_expected = 1'b1;
			ar_expected_pc = pc;
		end else begin
			model_hits = model_hits + 1;
		end
		fetch_valid = 1'b1;
		fetch_pc = pc;
		@(negedge clock);
		while (!fetch_ready) begin
			@(negedge clock);
		end
		check_word("fetch_data", mem_word(pc), fetch_data);
		if (ar_expected) begin
			$display("No AR request seen for the missed fetch at %h", pc);
			abort_run();
		end
		@(posedge clock);
		#1;
	endtask

	// Mix of sequential runs, repeats and random jumps.
	task automatic run_random_fetches(input int count);
		logic [addr_w-1:0] pc;
		int pick;
		pc = random_pc();
		for (int i = 0; i < count; i++) begin
			pick = $urandom_range(0, 99);
			if (pick < 50) begin
				pc = next_pc(pc);
			end else if (pick >= 65) begin
				pc = random_pc();
			end
			fetch_word(pc);
		end
	endtask

	task automatic check_counters(input string phase);
		fetch_valid = 1'b0;
		@(negedge clock);
		check_count({phase, "_hits"}, model_hits, hit_count);
		check_count({phase, "_misses"}, model_misses, miss_count);
		@(posedge clock);
		#1;
	endtask

	task automatic pulse_invalidate();
		fetch_valid = 1'b0;
		invalidate = 1'b1;
		@(posedge clock);
		#1;
		invalidate = 1'b0;
		for (int s = 0; s < num_sets; s++) begin
			model_valid[s] = 1'b0;
		end
	endtask

	// AXI4-Lite slave: random AR and R delays, response from the address decode.
	initial begin : axi_slave
		int delay;
		logic [addr_w-1:0] addr;
		axi_resp_t resp;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = OKAY;
		forever begin
			@(negedge clock);
			if (arvalid && !reset) begin
				delay = $urandom_range(0, max_delay);
				repeat (delay) @(negedge clock);
				@(posedge clock);
				#1;
				arready = 1'b1;
				@(negedge clock);
				addr = araddr;
				resp = decode_resp(addr);
				check_resp("r_resp", OKAY, resp);
				check_prot("ar_prot", instr_prot, arprot);
				if (!ar_expected) begin
					$display("AR request at %h for a fetch the model called a hit", addr);
					abort_run();
				end
				check_word("ar_addr", ar_expected_pc, addr);
				ar_expected = 1'b0;
				@(posedge clock);
				#1;
				arready = 1'b0;
				delay = $urandom_range(0, max_delay);
				repeat (delay) begin
					@(posedge clock);
					#1;
				end
				rvalid = 1'b1;
				rdata = mem_word(addr);
				rresp = resp;
				@(negedge clock);
				if (!rready) begin
					$display("R beat offered but the reader is not ready");
					abort_run();
				end
				@(posedge clock);
				#1;
				rvalid = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(limit_cycles * clock_period);
		$display("Timeout after %0d cycles, the cache stopped answering", limit_cycles);
		abort_run();
	end

	initial begin : main
		logic [addr_w-1:0] cached [$];
		void'($urandom(32'h0b8763b5));
		reset = 1'b1;
		fetch_valid = 1'b0;
		fetch_pc = '0;
		invalidate = 1'b0;
		model_hits = '0;
		model_misses = '0;
		ar_expected = 1'b0;
		ar_expected_pc = '0;
		for (int s = 0; s < num_sets; s++) begin
			model_valid[s] = 1'b0;
			model_tag[s] = '0;
		end
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;

		run_random_fetches(num_fetches);
		check_counters("random");

		// Every cached line must miss once after the sweep.
		for (int s = 0; s < num_sets; s++) begin
			if (model_valid[s]) begin
				cached.push_back({model_tag[s], s[set_bits-1:0], 2'b00});
			end
		end
		pulse_invalidate();
		foreach (cached[i]) begin
			fetch_word(cached[i]);
		end
		check_counters("refetch");

		run_random_fetches(num_fetches / 2);
		pulse_invalidate();
		run_random_fetches(num_fetches / 2);
		check_counters("mixed");

		if (uut.u_checker.fail_count != 0) begin
			$display("Checker assertions failed %0d times", uut.u_checker.fail_count);
			abort_run();
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src.f
hw/icache_pkg.sv
hw/icache_bram_1r1w.sv
hw/icache_ctrl.sv
hw/icache_axil_reader.sv
hw/icache_top.sv
sim/icache_checker.sv
sim/icache_tb.sv
